//--- hdl/cam_pkg.sv
// Camera capture back end shared types and constants
package cam_pkg;

   //////////////////////////////////////////////////////////////////////
   // Design constants
   //////////////////////////////////////////////////////////////////////

   // Must match the firmware DMA transfer length
   localparam int DMA_TRANSFER_LENGTH = 16;
   localparam int DMA_COUNT_W         = $clog2(DMA_TRANSFER_LENGTH);

   localparam int FIFO_DEPTH          = 32;
   localparam int FIFO_ADDR_W         = $clog2(FIFO_DEPTH);

   // Short window for simulation, pclk rate in the real design
   localparam int FPS_WINDOW_CYCLES   = 2000;

   localparam int SYNC_STAGES         = 2;

   //////////////////////////////////////////////////////////////////////
   // Pixel and bus types
   //////////////////////////////////////////////////////////////////////

   typedef struct packed {
      logic [7:0] blue;
      logic [7:0] green;
      logic [7:0] red;
   } rgb_pixel_t;

   // First pixel in the low half, also the FIFO word
   typedef struct packed {
      rgb_pixel_t pix1;
      rgb_pixel_t pix0;
   } pix_pair_t;

   // One 24-bit pixel per 32-bit lane
   typedef struct packed {
      logic [7:0] pad1;
      rgb_pixel_t pix1;
      logic [7:0] pad0;
      rgb_pixel_t pix0;
   } dma_word_t;

   typedef struct packed {
      logic fifo_empty;
      logic writer_armed;
      logic wready;
   } debug_status_t;

endpackage

//--- hdl/cam_capture_ctrl.sv
// Capture control, syncs the level controls and opens the capture window on vsync fall
`timescale 1ns/100ps

module cam_capture_ctrl import cam_pkg::*; (
   input  logic mipi_pclk,
   input  logic rst_n,
   input  logic trigger_capture_i,
   input  logic continuous_capture_i,
   input  logic rgb_gray_i,
   input  logic vsync_i,
   input  logic fifo_write_i,
   output logic capture_o,
   output logic gray_mode_o,
   output logic vsync_fall_o
);

   // Bit 0 trigger, bit 1 continuous, bit 2 gray
   logic [SYNC_STAGES-1:0][2:0] ctrl_sync;
   logic [2:0]                  ctrl_synced;
   logic                        trig_d;
   logic                        trig_rise;
   logic                        trig_hold;
   logic                        cont_hold;
   logic                        vsync_r;

   assign ctrl_synced  = ctrl_sync[SYNC_STAGES-1];
   assign trig_rise    = ctrl_synced[0] & ~trig_d;
   assign vsync_fall_o = vsync_r & ~vsync_i;

   always_ff @(posedge mipi_pclk) begin
      if (!rst_n) begin
         ctrl_sync   <= '0;
         trig_d      <= 1'b0;
         trig_hold   <= 1'b0;
         cont_hold   <= 1'b0;
         capture_o   <= 1'b0;
         gray_mode_o <= 1'b0;
         vsync_r     <= 1'b0;
      end else begin
         ctrl_sync   <= {ctrl_sync[SYNC_STAGES-2:0],
                         {rgb_gray_i, continuous_capture_i, trigger_capture_i}};
         trig_d      <= ctrl_synced[0];
         gray_mode_o <= ctrl_synced[2];
         vsync_r     <= vsync_i;

         // One trigger edge captures one frame, released by its first write
         if (trig_rise) begin
            trig_hold <= 1'b1;
         end else if (fifo_write_i) begin
            trig_hold <= 1'b0;
         end

         // Continuous mode stays on until reset
         if (ctrl_synced[1]) begin
            cont_hold <= 1'b1;
         end

         if ((trig_hold | cont_hold) & vsync_fall_o) begin
            capture_o <= 1'b1;
         end else if (capture_o & vsync_fall_o & ~cont_hold) begin
            capture_o <= 1'b0;
         end
      end
   end

endmodule

//--- hdl/cam_pixel_format.sv
// Pixel formatter, registers RGB or grayscale pixel pairs into FIFO words
`timescale 1ns/100ps

module cam_pixel_format import cam_pkg::*; (
   input  logic      mipi_pclk,
   input  logic      rst_n,
   input  pix_pair_t pix_i,
   input  logic      pix_valid_i,
   input  logic      capture_i,
   input  logic      gray_mode_i,
   output logic      fifo_we_o,
   output pix_pair_t fifo_wdata_o
);

   // Gray is (R + 2G + B) / 4, copied to all three channels
   function automatic rgb_pixel_t to_gray(input rgb_pixel_t p);
      logic [9:0] sum;
      rgb_pixel_t g;
      sum     = {2'b00, p.red} + {1'b0, p.green, 1'b0} + {2'b00, p.blue};
      g.red   = sum[9:2];
      g.green = sum[9:2];
      g.blue  = sum[9:2];
      return g;
   endfunction

   pix_pair_t gray_pair;

   assign gray_pair.pix0 = to_gray(pix_i.pix0);
   assign gray_pair.pix1 = to_gray(pix_i.pix1);

   always_ff @(posedge mipi_pclk) begin
      if (!rst_n) begin
         fifo_we_o <= 1'b0;
      end else begin
         fifo_we_o <= pix_valid_i & capture_i;
      end
   end

   always_ff @(posedge mipi_pclk) begin
      if (pix_valid_i) begin
         fifo_wdata_o <= gray_mode_i ? gray_pair : pix_i;
      end
   end

endmodule

//--- hdl/cam_dma_fifo.sv
// First-word-fall-through FIFO of pixel pairs with overflow and underflow strobes
`timescale 1ns/100ps

module cam_dma_fifo import cam_pkg::*; (
   input  logic      mipi_pclk,
   input  logic      rst_n,
   input  logic      we_i,
   input  pix_pair_t wdata_i,
   input  logic      re_i,
   output pix_pair_t rdata_o,
   output logic      empty_o,
   output logic      overflow_o,
   output logic      underflow_o
);

   pix_pair_t              mem [FIFO_DEPTH];
   logic [FIFO_ADDR_W-1:0] wr_ptr;
   logic [FIFO_ADDR_W-1:0] rd_ptr;
   logic [FIFO_ADDR_W:0]   count;
   logic                   full;
   logic                   do_write;
   logic                   do_read;

   assign full     = (count == (FIFO_ADDR_W+1)'(FIFO_DEPTH));
   assign empty_o  = (count == '0);
   assign do_write = we_i & ~full;
   assign do_read  = re_i & ~empty_o;

   // Head word is always on the output
   assign rdata_o  = mem[rd_ptr];

   always_ff @(posedge mipi_pclk) begin
      if (do_write) begin
         mem[wr_ptr] <= wdata_i;
      end
   end

   always_ff @(posedge mipi_pclk) begin
      if (!rst_n) begin
         wr_ptr      <= '0;
         rd_ptr      <= '0;
         count       <= '0;
         overflow_o  <= 1'b0;
         underflow_o <= 1'b0;
      end else begin
         if (do_write) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (do_read) begin
            rd_ptr <= rd_ptr + 1'b1;
         end

         case ({do_write, do_read})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase

         // Full writes are dropped
         overflow_o  <= we_i & full;
         underflow_o <= re_i & empty_o;
      end
   end

endmodule

//--- hdl/cam_dma_writer.sv
// DMA writer, sends one fixed-length transfer per DMA init edge from the FIFO
`timescale 1ns/100ps

module cam_dma_writer import cam_pkg::*; (
   input  logic      mipi_pclk,
   input  logic      rst_n,
   input  logic      dma_init_done_i,
   input  logic      dma_wready_i,
   input  logic      fifo_empty_i,
   input  pix_pair_t fifo_rdata_i,
   output logic      fifo_re_o,
   output logic      dma_wvalid_o,
   output logic      dma_wlast_o,
   output dma_word_t dma_wdata_o,
   output logic      armed_o
);

   logic [SYNC_STAGES-1:0] init_sync;
   logic                   init_d;
   logic                   init_rise;
   logic [DMA_COUNT_W-1:0] beat_count;
   logic                   beat;
   logic                   last_beat;

   assign init_rise = init_sync[SYNC_STAGES-1] & ~init_d;

   // Valid only with wready, so a low wready backs up into the FIFO
   assign fifo_re_o    = armed_o & dma_wready_i & ~fifo_empty_i;
   assign dma_wvalid_o = fifo_re_o;
   assign beat         = dma_wvalid_o & dma_wready_i;
   assign last_beat    = (beat_count == DMA_COUNT_W'(DMA_TRANSFER_LENGTH - 1));
   assign dma_wlast_o  = dma_wvalid_o & last_beat;

   assign dma_wdata_o.pad1 = 8'h00;
   assign dma_wdata_o.pix1 = fifo_rdata_i.pix1;
   assign dma_wdata_o.pad0 = 8'h00;
   assign dma_wdata_o.pix0 = fifo_rdata_i.pix0;

   always_ff @(posedge mipi_pclk) begin
      if (!rst_n) begin
         init_sync  <= '0;
         init_d     <= 1'b0;
         armed_o    <= 1'b0;
         beat_count <= '0;
      end else begin
         init_sync <= {init_sync[SYNC_STAGES-2:0], dma_init_done_i};
         init_d    <= init_sync[SYNC_STAGES-1];

         if (init_rise) begin
            armed_o <= 1'b1;
         end else if (beat & last_beat) begin
            armed_o <= 1'b0;
         end

         if (beat) begin
            beat_count <= last_beat ? '0 : beat_count + 1'b1;
         end
      end
   end

endmodule

//--- hdl/cam_debug_status.sv
// Debug status, sticky FIFO errors, traffic counters and frame rate measurement
`timescale 1ns/100ps

module cam_debug_status import cam_pkg::*; (
   input  logic        mipi_pclk,
   input  logic        rst_n,
   input  logic        fifo_overflow_i,
   input  logic        fifo_underflow_i,
   input  logic        fifo_we_i,
   input  logic        dma_beat_i,
   input  logic        vsync_fall_i,
   output logic        fifo_overflow_o,
   output logic        fifo_underflow_o,
   output logic [31:0] wcount_o,
   output logic [31:0] rcount_o,
   output logic [31:0] frames_per_second_o
);

   logic [31:0] timer_count;
   logic [31:0] frame_count;
   logic        window_end;

   assign window_end = (timer_count == 32'(FPS_WINDOW_CYCLES));

   always_ff @(posedge mipi_pclk) begin
      if (!rst_n) begin
         fifo_overflow_o     <= 1'b0;
         fifo_underflow_o    <= 1'b0;
         wcount_o            <= '0;
         rcount_o            <= '0;
         timer_count         <= '0;
         frame_count         <= '0;
         frames_per_second_o <= '0;
      end else begin
         //////////////////////////////////////////////////////////////////
         // Sticky flags and counters
         //////////////////////////////////////////////////////////////////
         if (fifo_overflow_i) begin
            fifo_overflow_o <= 1'b1;
         end
         if (fifo_underflow_i) begin
            fifo_underflow_o <= 1'b1;
         end
         if (fifo_we_i) begin
            wcount_o <= wcount_o + 1'b1;
         end
         if (dma_beat_i) begin
            rcount_o <= rcount_o + 1'b1;
         end

         //////////////////////////////////////////////////////////////////
         // Frames per window, frame rate assumed above one per window
         //////////////////////////////////////////////////////////////////
         if (window_end) begin
            timer_count         <= '0;
            frame_count         <= '0;
            frames_per_second_o <= frame_count;
         end else begin
            timer_count <= timer_count + 1'b1;
            if (vsync_fall_i) begin
               frame_count <= frame_count + 1'b1;
            end
         end
      end
   end

endmodule

//--- hdl/cam_coral_top.sv
// Camera capture back end top, from 2PPC RGB pixels to DMA write beats
`timescale 1ns/100ps

module cam_coral_top import cam_pkg::*; (
   input  logic          mipi_pclk,
   input  logic          rst_n,

   // Demosaiced pixel stream
   input  pix_pair_t     pix_i,
   input  logic          pix_valid_i,
   input  logic          vsync_i,

   // Controls, asynchronous levels
   input  logic          trigger_capture_i,
   input  logic          continuous_capture_i,
   input  logic          rgb_gray_i,
   input  logic          dma_init_done_i,

   // DMA write channel
   input  logic          dma_wready_i,
   output logic          dma_wvalid_o,
   output logic          dma_wlast_o,
   output dma_word_t     dma_wdata_o,

   // Debug
   output logic          fifo_overflow_o,
   output logic          fifo_underflow_o,
   output logic [31:0]   wcount_o,
   output logic [31:0]   rcount_o,
   output logic [31:0]   frames_per_second_o,
   output debug_status_t dma_status_o
);

   logic      capture;
   logic      gray_mode;
   logic      vsync_fall;
   logic      fifo_we;
   pix_pair_t fifo_wdata;
   logic      fifo_re;
   pix_pair_t fifo_rdata;
   logic      fifo_empty;
   logic      fifo_overflow;
   logic      fifo_underflow;
   logic      writer_armed;
   logic      dma_beat;

   assign dma_beat                  = dma_wvalid_o & dma_wready_i;
   assign dma_status_o.fifo_empty   = fifo_empty;
   assign dma_status_o.writer_armed = writer_armed;
   assign dma_status_o.wready       = dma_wready_i;

   cam_capture_ctrl i_capture_ctrl (
      .mipi_pclk            (mipi_pclk),
      .rst_n                (rst_n),
      .trigger_capture_i    (trigger_capture_i),
      .continuous_capture_i (continuous_capture_i),
      .rgb_gray_i           (rgb_gray_i),
      .vsync_i              (vsync_i),
      .fifo_write_i         (fifo_we),
      .capture_o            (capture),
      .gray_mode_o          (gray_mode),
      .vsync_fall_o         (vsync_fall)
   );

   cam_pixel_format i_pixel_format (
      .mipi_pclk    (mipi_pclk),
      .rst_n        (rst_n),
      .pix_i        (pix_i),
      .pix_valid_i  (pix_valid_i),
      .capture_i    (capture),
      .gray_mode_i  (gray_mode),
      .fifo_we_o    (fifo_we),
      .fifo_wdata_o (fifo_wdata)
   );

   cam_dma_fifo i_dma_fifo (
      .mipi_pclk   (mipi_pclk),
      .rst_n       (rst_n),
      .we_i        (fifo_we),
      .wdata_i     (fifo_wdata),
      .re_i        (fifo_re),
      .rdata_o     (fifo_rdata),
      .empty_o     (fifo_empty),
      .overflow_o  (fifo_overflow),
      .underflow_o (fifo_underflow)
   );

   cam_dma_writer i_dma_writer (
      .mipi_pclk       (mipi_pclk),
      .rst_n           (rst_n),
      .dma_init_done_i (dma_init_done_i),
      .dma_wready_i    (dma_wready_i),
      .fifo_empty_i    (fifo_empty),
      .fifo_rdata_i    (fifo_rdata),
      .fifo_re_o       (fifo_re),
      .dma_wvalid_o    (dma_wvalid_o),
      .dma_wlast_o     (dma_wlast_o),
      .dma_wdata_o     (dma_wdata_o),
      .armed_o         (writer_armed)
   );

   cam_debug_status i_debug_status (
      .mipi_pclk           (mipi_pclk),
      .rst_n               (rst_n),
      .fifo_overflow_i     (fifo_overflow),
      .fifo_underflow_i    (fifo_underflow),
      .fifo_we_i           (fifo_we),
      .dma_beat_i          (dma_beat),
      .vsync_fall_i        (vsync_fall),
      .fifo_overflow_o     (fifo_overflow_o),
      .fifo_underflow_o    (fifo_underflow_o),
      .wcount_o            (wcount_o),
      .rcount_o            (rcount_o),
      .frames_per_second_o (frames_per_second_o)
   );

endmodule

//--- verification/tb_cam_coral.sv
// Table-driven testbench for the camera capture back end with a DMA sink model
`timescale 1ns/100ps

module tb_cam_coral import cam_pkg::*; ();

   localparam logic [1:0]  MODE_NONE    = 2'd0;
   localparam logic [1:0]  MODE_TRIG    = 2'd1;
   localparam logic [1:0]  MODE_CONT    = 2'd2;
   localparam logic [1:0]  RDY_ALWAYS   = 2'd0;
   localparam logic [1:0]  RDY_RANDOM   = 2'd1;
   localparam logic [1:0]  RDY_LOW      = 2'd2;
   localparam int          NUM_TESTS    = 5;
   localparam int          BEAT_TIMEOUT = 1000;
   localparam int          WINDOW       = FPS_WINDOW_CYCLES + 1;
   localparam logic [31:0] LCG_SEED     = 32'h28e4_a607;

   typedef struct packed {
      logic [1:0] mode;
      logic       gray;
      logic [3:0] frames;
      logic [7:0] pairs;
      logic [1:0] rdy;
      logic       init;
   } test_t;

   logic          mipi_pclk;
   logic          rst_n;
   pix_pair_t     pix_i;
   logic          pix_valid_i;
   logic          vsync_i;
   logic          trigger_capture_i;
   logic          continuous_capture_i;
   logic          rgb_gray_i;
   logic          dma_init_done_i;
   logic          dma_wready_i = 1'b1;
   logic          dma_wvalid_o;
   logic          dma_wlast_o;
   dma_word_t     dma_wdata_o;
   logic          fifo_overflow_o;
   logic          fifo_underflow_o;
   logic [31:0]   wcount_o;
   logic [31:0]   rcount_o;
   logic [31:0]   frames_per_second_o;
   debug_status_t dma_status_o;

   test_t       tests [NUM_TESTS];
   dma_word_t   exp_q [$];
   dma_word_t   exp_word;
   logic        exp_last;
   logic        exp_ovf = 1'b0;
   logic        cont_latched = 1'b0;
   logic [1:0]  rdy_mode = RDY_ALWAYS;
   logic [31:0] pix_seed = LCG_SEED;
   logic [31:0] rdy_seed = LCG_SEED;
   int          run_cycles = 0;
   int          beat_count = 0;
   int          beat_errs = 0;
   int          err_count = 0;
   int          test_count = 0;
   int          exp_wcount = 0;
   int          exp_rcount = 0;

   cam_coral_top i_dut (.*);

   //////////////////////////////////////////////////////////////////////
   // Reference rules
   //////////////////////////////////////////////////////////////////////

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   function automatic rgb_pixel_t gray_pixel(input rgb_pixel_t p);
      int         lum;
      rgb_pixel_t g;
      lum     = (int'(p.red) + 2 * int'(p.green) + int'(p.blue)) / 4;
      g.red   = 8'(lum);
      g.green = 8'(lum);
      g.blue  = 8'(lum);
      return g;
   endfunction

   // Pad bytes stay zero
   function automatic dma_word_t pack_word(input pix_pair_t p, input logic gray);
      dma_word_t w;
      w      = '0;
      w.pix0 = gray ? gray_pixel(p.pix0) : p.pix0;
      w.pix1 = gray ? gray_pixel(p.pix1) : p.pix1;
      return w;
   endfunction

   //////////////////////////////////////////////////////////////////////
   // Clock, DMA ready source and beat monitor
   //////////////////////////////////////////////////////////////////////

   initial begin
      mipi_pclk = 1'b0;
      forever #2 mipi_pclk = ~mipi_pclk;
   end

   // Mirrors the DUT window timer, which starts counting out of reset
   always @(posedge mipi_pclk) begin
      if (rst_n) begin
         run_cycles <= run_cycles + 1;
      end
   end

   always @(negedge mipi_pclk) begin
      if (rdy_mode == RDY_RANDOM) begin
         rdy_seed     = lcg_next(rdy_seed);
         dma_wready_i = rdy_seed[20];
      end else begin
         dma_wready_i = (rdy_mode == RDY_ALWAYS);
      end
   end

   // Inputs settle after the falling edge, so this is the beat of the next rising edge
   always @(negedge mipi_pclk) begin
      #1;
      if (dma_wvalid_o && dma_wready_i) begin
         exp_last = ((beat_count % DMA_TRANSFER_LENGTH) == DMA_TRANSFER_LENGTH - 1);
         if (exp_q.size() == 0) begin
            $display("DMA beat %0d arrived while no word was expected", beat_count);
            beat_errs++;
         end else begin
            exp_word = exp_q.pop_front();
            if (dma_wdata_o !== exp_word) begin
               $display("Mismatch dma_wdata_o beat %0d: got %h, expected %h",
                        beat_count, dma_wdata_o, exp_word);
               beat_errs++;
            end
         end
         if (dma_wlast_o !== exp_last) begin
            $display("Mismatch dma_wlast_o beat %0d: got %h, expected %h",
                     beat_count, dma_wlast_o, exp_last);
            beat_errs++;
         end
         beat_count++;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Stimulus tasks
   //////////////////////////////////////////////////////////////////////

   task automatic wait_cycles(input int n);
      repeat (n) @(negedge mipi_pclk);
   endtask

   task automatic pulse_vsync();
      @(negedge mipi_pclk);
      vsync_i = 1'b1;
      wait_cycles(3);
      vsync_i = 1'b0;
      wait_cycles(4);
   endtask

   task automatic send_frame(input int pairs, input logic captured, input logic gray);
      pix_pair_t p;
      for (int i = 0; i < pairs; i++) begin
         @(negedge mipi_pclk);
         pix_seed    = lcg_next(pix_seed);
         p.pix0      = pix_seed[31:8];
         pix_seed    = lcg_next(pix_seed);
         p.pix1      = pix_seed[31:8];
         pix_i       = p;
         pix_valid_i = 1'b1;
         if (captured) begin
            exp_wcount++;
            // No reads while a frame streams in, so the queue mirrors the FIFO fill
            if (exp_q.size() < FIFO_DEPTH) begin
               exp_q.push_back(pack_word(p, gray));
               exp_rcount++;
            end else begin
               exp_ovf = 1'b1;
            end
         end
      end
      @(negedge mipi_pclk);
      pix_valid_i = 1'b0;
      wait_cycles(4);
   endtask

   task automatic drain_transfer(output logic ok);
      int target;
      int waited;
      target = beat_count + DMA_TRANSFER_LENGTH;
      waited = 0;
      @(negedge mipi_pclk);
      dma_init_done_i = 1'b1;
      wait_cycles(4);
      dma_init_done_i = 1'b0;
      while (beat_count < target && waited < BEAT_TIMEOUT) begin
         @(negedge mipi_pclk);
         waited++;
      end
      ok = (beat_count >= target);
      if (!ok) begin
         $display("Timeout waiting for a DMA transfer, %0d beats short", target - beat_count);
         err_count++;
      end
   endtask

   task automatic drain_fifo();
      logic ok;
      ok = 1'b1;
      while (ok && exp_q.size() >= DMA_TRANSFER_LENGTH) begin
         drain_transfer(ok);
      end
   endtask

   task automatic run_test(input test_t t);
      logic          captured;
      int            errs_before;
      debug_status_t exp_status;
      errs_before = err_count + beat_errs;
      @(negedge mipi_pclk);
      rdy_mode             = t.rdy;
      rgb_gray_i           = t.gray;
      continuous_capture_i = (t.mode == MODE_CONT);
      trigger_capture_i    = (t.mode == MODE_TRIG);
      wait_cycles(6);
      trigger_capture_i = 1'b0;
      wait_cycles(6);
      if (t.mode == MODE_CONT) begin
         cont_latched = 1'b1;
      end

      for (int f = 0; f < int'(t.frames); f++) begin
         // One trigger edge captures only the next frame
         captured = cont_latched || (t.mode == MODE_TRIG && f == 0);
         pulse_vsync();
         send_frame(int'(t.pairs), captured, t.gray);
         if (t.init && t.rdy != RDY_LOW) begin
            drain_fifo();
         end
      end
      pulse_vsync();

      // Release the stalled DMA and empty the FIFO
      if (t.init && t.rdy == RDY_LOW) begin
         rdy_mode = RDY_ALWAYS;
         drain_fifo();
      end
      wait_cycles(4);
      // Wait for the falling-edge wready update to settle
      #1;

      if (exp_q.size() != 0) begin
         $display("%0d expected DMA words were never delivered", exp_q.size());
         err_count++;
      end
      if (wcount_o !== 32'(exp_wcount)) begin
         $display("Mismatch wcount_o: got %h, expected %h", wcount_o, exp_wcount);
         err_count++;
      end
      if (rcount_o !== 32'(exp_rcount)) begin
         $display("Mismatch rcount_o: got %h, expected %h", rcount_o, exp_rcount);
         err_count++;
      end
      if (fifo_overflow_o !== exp_ovf) begin
         $display("Mismatch fifo_overflow_o: got %h, expected %h", fifo_overflow_o, exp_ovf);
         err_count++;
      end
      if (fifo_underflow_o !== 1'b0) begin
         $display("Mismatch fifo_underflow_o: got %h, expected %h", fifo_underflow_o, 1'b0);
         err_count++;
      end
      // Drained FIFO, writer disarmed after its last beat
      exp_status.fifo_empty   = 1'b1;
      exp_status.writer_armed = 1'b0;
      exp_status.wready       = dma_wready_i;
      if (dma_status_o !== exp_status) begin
         $display("Mismatch dma_status_o: got %h, expected %h", dma_status_o, exp_status);
         err_count++;
      end
      test_count++;
      $display("Test %0d finished with %0d errors", test_count,
               err_count + beat_errs - errs_before);
   endtask

   task automatic measure_fps();
      int waited;
      int errs_before;
      errs_before = err_count;
      waited      = 0;
      // Align to the first cycle of a fresh window
      while ((run_cycles % WINDOW) != 1 && waited < 2 * WINDOW) begin
         @(negedge mipi_pclk);
         waited++;
      end
      if (waited >= 2 * WINDOW) begin
         $display("Timeout waiting for the start of a frame rate window");
         err_count++;
      end
      repeat (4) pulse_vsync();
      waited = 0;
      while ((run_cycles % WINDOW) != 1 && waited < 2 * WINDOW) begin
         @(negedge mipi_pclk);
         waited++;
      end
      if (waited >= 2 * WINDOW) begin
         $display("Timeout waiting for a frame rate window boundary");
         err_count++;
      end else if (frames_per_second_o !== 32'd4) begin
         $display("Mismatch frames_per_second_o: got %h, expected %h",
                  frames_per_second_o, 32'd4);
         err_count++;
      end
      test_count++;
      $display("Test %0d finished with %0d errors", test_count, err_count - errs_before);
   endtask

   //////////////////////////////////////////////////////////////////////
   // Test sequence
   //////////////////////////////////////////////////////////////////////

   initial begin
      rst_n                = 1'b0;
      pix_i                = '0;
      pix_valid_i          = 1'b0;
      vsync_i              = 1'b0;
      trigger_capture_i    = 1'b0;
      continuous_capture_i = 1'b0;
      rgb_gray_i           = 1'b0;
      dma_init_done_i      = 1'b0;

      // Mode, gray, frames, pairs per frame, wready, init_done
      tests[0] = '{MODE_NONE, 1'b0, 4'd1, 8'd16, RDY_ALWAYS, 1'b0};
      tests[1] = '{MODE_TRIG, 1'b0, 4'd2, 8'd16, RDY_ALWAYS, 1'b1};
      tests[2] = '{MODE_TRIG, 1'b1, 4'd1, 8'd16, RDY_ALWAYS, 1'b1};
      tests[3] = '{MODE_CONT, 1'b0, 4'd3, 8'd16, RDY_RANDOM, 1'b1};
      tests[4] = '{MODE_NONE, 1'b0, 4'd1, 8'd40, RDY_LOW, 1'b1};

      repeat (3) @(posedge mipi_pclk);
      @(negedge mipi_pclk);
      rst_n = 1'b1;

      for (int i = 0; i < NUM_TESTS; i++) begin
         run_test(tests[i]);
      end
      measure_fps();

      $display("Tests run %0d, errors %0d", test_count, err_count + beat_errs);
      if (err_count + beat_errs == 0) begin
         $display("TB PASSED");
      end else begin
         $display("TB FAILED");
      end
      $finish;
   end

endmodule

//--- verilog.f
hdl/cam_pkg.sv
hdl/cam_capture_ctrl.sv
hdl/cam_pixel_format.sv
hdl/cam_dma_fifo.sv
hdl/cam_dma_writer.sv
hdl/cam_debug_status.sv
hdl/cam_coral_top.sv
verification/tb_cam_coral.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_cam_coral
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep "TB PASSED" > /dev/null

clean:
	rm -rf $(OBJ_DIR)
